// ==== Makefile ====
TOP = rmt_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== common/rmt_pkg.sv ====
package rmt_pkg;

	localparam int DATA_WIDTH  = 64;
	localparam int VLAN_WIDTH  = 12;
	localparam int KIND_WIDTH  = 4;
	localparam int CONT_WIDTH  = 16;
	localparam int NUM_CONT    = 3;
	localparam int NUM_STAGES  = 3;
	localparam int TABLE_DEPTH = 16;
	localparam int IDX_WIDTH   = $clog2(TABLE_DEPTH);  // low vlan bits select the entry
	localparam int STAGE_WIDTH = 4;
	localparam int OP_WIDTH    = 2;
	localparam int CSEL_WIDTH  = 2;

	localparam logic [KIND_WIDTH-1:0] KIND_DATA = 4'd0;
	localparam logic [KIND_WIDTH-1:0] KIND_CTRL = 4'd1;

	localparam logic [OP_WIDTH-1:0] OP_NOP = 2'd0;
	localparam logic [OP_WIDTH-1:0] OP_SET = 2'd1;
	localparam logic [OP_WIDTH-1:0] OP_ADD = 2'd2;

	// low bit of each field in the first beat
	localparam int VLAN_LO  = 52;
	localparam int KIND_LO  = 48;
	localparam int CONT_LO  = 0;   // containers of a data packet in 47..0
	localparam int STAGE_LO = 44;  // control packet fields
	localparam int IDX_LO   = 40;
	localparam int OP_LO    = 36;
	localparam int CSEL_LO  = 32;
	localparam int IMM_LO   = 0;

	localparam int PKT_FIFO_DEPTH = 32;
	localparam int PHV_FIFO_DEPTH = 8;
	// 5 cycles from s_axis accept to phv fifo write, plus one spare
	localparam int FIFO_SLACK = 6;

	localparam int CTRL_WIDTH = STAGE_WIDTH + IDX_WIDTH + OP_WIDTH + CSEL_WIDTH + CONT_WIDTH;

	typedef struct packed {
		logic [VLAN_WIDTH-1:0]                vlan;
		logic [NUM_CONT-1:0][CONT_WIDTH-1:0]  cont;
	} phv_t;

	typedef struct packed {
		logic [OP_WIDTH-1:0]   op;
		logic [CSEL_WIDTH-1:0] csel;
		logic [CONT_WIDTH-1:0] imm;
	} action_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic                  last;
	} pkt_beat_t;

endpackage

// ==== src.f ====
common/rmt_pkg.sv
verilog/sync_fifo.sv
verilog/pkt_filter.sv
verilog/phv_parser.sv
stage/match_action_stage.sv
verilog/phv_deparser.sv
verilog/rmt_top.sv
tb/rmt_tb.sv

// ==== stage/match_action_stage.sv ====
module match_action_stage import rmt_pkg::*; #(
	parameter int STAGE_ID = 0
) (
	input  logic                  clk,
	input  logic                  aresetn,
	input  phv_t                  phv_in,
	input  logic                  phv_valid_in,
	input  logic [CTRL_WIDTH-1:0] ctrl_in,
	input  logic                  ctrl_valid_in,
	output phv_t                  phv_out,
	output logic                  phv_valid_out,
	output logic [CTRL_WIDTH-1:0] ctrl_out,
	output logic                  ctrl_valid_out
);

	logic [STAGE_WIDTH-1:0] c_stage;
	logic [IDX_WIDTH-1:0]   c_idx;
	action_t                c_act;
	logic                   tbl_we;

	action_t table_r [TABLE_DEPTH];
	action_t act;
	phv_t    phv_next;

	assign {c_stage, c_idx, c_act} = ctrl_in;
	assign tbl_we = ctrl_valid_in && (c_stage == STAGE_WIDTH'(STAGE_ID));

	// lookup by low vlan bits
	assign act = table_r[phv_in.vlan[IDX_WIDTH-1:0]];

	// an out of range container select leaves the phv alone
	always_comb begin
		phv_next = phv_in;
		for (int i = 0; i < NUM_CONT; i++) begin
			if (act.csel == CSEL_WIDTH'(i)) begin
				case (act.op)
					OP_SET:  phv_next.cont[i] = act.imm;
					OP_ADD:  phv_next.cont[i] = phv_in.cont[i] + act.imm;  // mod 2^16
					default: phv_next.cont[i] = phv_in.cont[i];
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			for (int i = 0; i < TABLE_DEPTH; i++)
				table_r[i] <= '{op: OP_NOP, default: '0};
		end else if (tbl_we) begin
			table_r[c_idx] <= c_act;
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			phv_valid_out  <= 1'b0;
			ctrl_valid_out <= 1'b0;
		end else begin
			phv_valid_out  <= phv_valid_in;
			ctrl_valid_out <= ctrl_valid_in;  // every stage forwards control words
		end
	end

	always_ff @(posedge clk) begin
		phv_out  <= phv_next;
		ctrl_out <= ctrl_in;
	end

endmodule

// ==== tb/rmt_tb.sv ====
module rmt_tb import rmt_pkg::*;;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 5;
	localparam int DRIVE_DLY    = 1;
	localparam int MAX_LEN      = 6;
	localparam int MAX_PKTS     = 110;  // upper bound over all tests
	localparam int WATCHDOG_CYCLES = MAX_PKTS * MAX_LEN * 20 + 500;

	logic                  clk = 1'b0;
	logic                  aresetn;
	logic [15:0]           vlan_drop_flags;
	logic [31:0]           ctrl_token;
	logic [DATA_WIDTH-1:0] s_axis_tdata;
	logic                  s_axis_tvalid;
	logic                  s_axis_tready;
	logic                  s_axis_tlast;
	logic [DATA_WIDTH-1:0] m_axis_tdata;
	logic                  m_axis_tvalid;
	logic                  m_axis_tready;
	logic                  m_axis_tlast;

	integer seed = 32'hf2d8;
	integer bp_seed = 32'hf2d8;  // own stream for the ready toggle

	logic [DATA_WIDTH:0] exp_q [$];  // {data, last}
	action_t             ref_tbl [NUM_STAGES][TABLE_DEPTH];
	logic [31:0]         ctrl_sent = 32'd0;
	int                  errors = 0;
	int                  beats_seen = 0;
	int                  test_err_base = 0;
	logic                bp_on = 1'b0;
	logic                s_ready_low_seen = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	rmt_top rmt_top_i (
		.clk             (clk),
		.aresetn         (aresetn),
		.vlan_drop_flags (vlan_drop_flags),
		.ctrl_token      (ctrl_token),
		.s_axis_tdata    (s_axis_tdata),
		.s_axis_tvalid   (s_axis_tvalid),
		.s_axis_tready   (s_axis_tready),
		.s_axis_tlast    (s_axis_tlast),
		.m_axis_tdata    (m_axis_tdata),
		.m_axis_tvalid   (m_axis_tvalid),
		.m_axis_tready   (m_axis_tready),
		.m_axis_tlast    (m_axis_tlast)
	);

	// expected first beat after all stages with the tables written so far
	function automatic logic [DATA_WIDTH-1:0] expect_header(input logic [DATA_WIDTH-1:0] beat);
		logic [CONT_WIDTH-1:0] cont [NUM_CONT];
		logic [DATA_WIDTH-1:0] result;
		action_t               act;
		for (int c = 0; c < NUM_CONT; c++)
			cont[c] = beat[CONT_LO + c * CONT_WIDTH +: CONT_WIDTH];
		for (int s = 0; s < NUM_STAGES; s++) begin
			act = ref_tbl[s][beat[VLAN_LO +: IDX_WIDTH]];
			if (act.csel < NUM_CONT) begin
				if (act.op == OP_SET)
					cont[act.csel] = act.imm;
				else if (act.op == OP_ADD)
					cont[act.csel] = cont[act.csel] + act.imm;  // wraps at 16 bits
			end
		end
		result = beat;
		for (int c = 0; c < NUM_CONT; c++)
			result[CONT_LO + c * CONT_WIDTH +: CONT_WIDTH] = cont[c];
		return result;
	endfunction

	// called just after a rising edge and returns just after the accepting edge
	task automatic send_beat(input logic [DATA_WIDTH-1:0] data, input logic last);
		s_axis_tdata  = data;
		s_axis_tlast  = last;
		s_axis_tvalid = 1'b1;
		while (!s_axis_tready) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
		@(posedge clk);
		#DRIVE_DLY;
		s_axis_tvalid = 1'b0;
	endtask

	task automatic send_data_pkt(input logic [IDX_WIDTH-1:0] idx, input int len);
		logic [DATA_WIDTH-1:0] beat;
		logic                  keep;
		beat = {$random(seed), $random(seed)};
		beat[VLAN_LO +: VLAN_WIDTH] = {8'($random(seed)), idx};
		beat[KIND_LO +: KIND_WIDTH] = KIND_DATA;
		keep = !vlan_drop_flags[idx];
		if (keep)
			exp_q.push_back({expect_header(beat), len == 1});
		for (int i = 0; i < len; i++) begin
			if (i > 0) begin
				beat = {$random(seed), $random(seed)};  // payload passes untouched
				if (keep)
					exp_q.push_back({beat, i == len - 1});
			end
			send_beat(beat, i == len - 1);
		end
	endtask

	task automatic send_ctrl_pkt(input logic [IDX_WIDTH-1:0] vlan_idx, input int stage,
			input logic [IDX_WIDTH-1:0] idx, input logic [OP_WIDTH-1:0] op,
			input logic [CSEL_WIDTH-1:0] csel, input logic [CONT_WIDTH-1:0] imm,
			input int len);
		logic [DATA_WIDTH-1:0] beat;
		action_t               act;
		beat = '0;
		beat[VLAN_LO +: VLAN_WIDTH]   = {8'($random(seed)), vlan_idx};
		beat[KIND_LO +: KIND_WIDTH]   = KIND_CTRL;
		beat[STAGE_LO +: STAGE_WIDTH] = STAGE_WIDTH'(stage);
		beat[IDX_LO +: IDX_WIDTH]     = idx;
		beat[OP_LO +: OP_WIDTH]       = op;
		beat[CSEL_LO +: CSEL_WIDTH]   = csel;
		beat[IMM_LO +: CONT_WIDTH]    = imm;
		act.op   = op;
		act.csel = csel;
		act.imm  = imm;
		if (!vlan_drop_flags[vlan_idx]) begin
			ctrl_sent = ctrl_sent + 32'd1;
			if (stage < NUM_STAGES)
				ref_tbl[stage][idx] = act;
		end
		send_beat(beat, len == 1);
		for (int i = 1; i < len; i++)
			send_beat({$random(seed), $random(seed)}, i == len - 1);  // discarded by the DUT
	endtask

	task automatic send_random_pkt();
		if (({$random(seed)} % 5) == 0)
			send_ctrl_pkt(4'($random(seed)), {$random(seed)} % NUM_STAGES, 4'($random(seed)),
				2'($random(seed)), 2'($random(seed)), 16'($random(seed)), 1 + {$random(seed)} % 2);
		else
			send_data_pkt(4'($random(seed)), 1 + {$random(seed)} % MAX_LEN);
	endtask

	task automatic check_token();
		if (ctrl_token !== ctrl_sent) begin
			$display("FAIL %0t ctrl_token expected %0d got %0d", $time, ctrl_sent, ctrl_token);
			errors++;
		end
	endtask

	// wait for the output to catch up, then a few idle cycles for stray beats
	task automatic end_test(input string name);
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (8) @(negedge clk);
		$display("test %s done: %0d errors", name, errors - test_err_base);
		test_err_base = errors;
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// values settle well before the falling edge
	always @(negedge clk) begin
		if (aresetn && bp_on && !s_axis_tready)
			s_ready_low_seen = 1'b1;
		if (aresetn && m_axis_tvalid && m_axis_tready) begin
			if (exp_q.size() == 0) begin
				$display("unexpected output beat at %0t, data %h", $time, m_axis_tdata);
				errors++;
			end else begin
				if (m_axis_tdata !== exp_q[0][DATA_WIDTH:1]) begin
					$display("FAIL %0t m_axis_tdata expected %h got %h", $time,
						exp_q[0][DATA_WIDTH:1], m_axis_tdata);
					errors++;
				end
				if (m_axis_tlast !== exp_q[0][0]) begin
					$display("FAIL %0t m_axis_tlast expected %b got %b", $time,
						exp_q[0][0], m_axis_tlast);
					errors++;
				end
				void'(exp_q.pop_front());
				beats_seen++;
			end
		end
	end

	// output ready stays high unless back-pressure is on
	initial begin
		int stall_left;
		stall_left = 0;
		m_axis_tready = 1'b0;
		forever begin
			@(posedge clk);
			#DRIVE_DLY;
			if (!bp_on) begin
				m_axis_tready = 1'b1;
			end else if (stall_left > 0) begin
				m_axis_tready = 1'b0;
				stall_left--;
			end else if (({$random(bp_seed)} % 8) == 0) begin
				stall_left = 10 + {$random(bp_seed)} % 30;  // long low stretch
				m_axis_tready = 1'b0;
			end else begin
				m_axis_tready = ({$random(bp_seed)} % 4) != 0;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: output stalled with %0d expected beats still missing", exp_q.size());
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		s_axis_tdata    = '0;
		s_axis_tvalid   = 1'b0;
		s_axis_tlast    = 1'b0;
		vlan_drop_flags = 16'h0000;
		aresetn         = 1'b0;
		for (int s = 0; s < NUM_STAGES; s++)
			for (int i = 0; i < TABLE_DEPTH; i++)
				ref_tbl[s][i] = '0;  // nop
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		aresetn = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;

		for (int p = 0; p < 8; p++)
			send_data_pkt(4'($random(seed)), 1 + {$random(seed)} % MAX_LEN);
		end_test("pass_through");

		// several stages on container 0 of vlan index 3
		send_ctrl_pkt(4'd1, 0, 4'd3, OP_SET, 2'd0, 16'h1234, 1);
		send_ctrl_pkt(4'd1, 1, 4'd3, OP_ADD, 2'd0, 16'h0101, 1);
		send_ctrl_pkt(4'd1, 2, 4'd3, OP_ADD, 2'd0, 16'hff00, 2);
		send_ctrl_pkt(4'd2, 0, 4'd5, OP_ADD, 2'd1, 16'hfff0, 1);
		send_ctrl_pkt(4'd2, 2, 4'd5, OP_SET, 2'd2, 16'hbeef, 1);
		send_ctrl_pkt(4'd2, 1, 4'd9, OP_ADD, 2'd2, 16'h8001, 1);
		for (int p = 0; p < 24; p++) begin
			if (p % 6 == 5)
				send_ctrl_pkt(4'd0, {$random(seed)} % NUM_STAGES, 4'd9, 2'($random(seed)),
					2'($random(seed)), 16'($random(seed)), 1);
			else
				send_data_pkt(p % 3 == 0 ? 4'd3 : (p % 3 == 1 ? 4'd5 : 4'd9),
					1 + {$random(seed)} % MAX_LEN);
		end
		end_test("set_add");

		vlan_drop_flags = 16'h0421;  // indices 0, 5 and 10
		for (int p = 0; p < 12; p++)
			send_data_pkt(4'(p), 1 + {$random(seed)} % MAX_LEN);
		end_test("drop_filter");

		send_ctrl_pkt(4'd1, 1, 4'd7, OP_SET, 2'd2, 16'h00aa, 2);
		send_ctrl_pkt(4'd0, 0, 4'd7, OP_SET, 2'd0, 16'hdead, 1);
		send_ctrl_pkt(4'd2, 0, 4'd7, OP_ADD, 2'd2, 16'h0011, 1);
		send_ctrl_pkt(4'd5, 2, 4'd7, OP_SET, 2'd1, 16'h5555, 2);
		send_data_pkt(4'd7, 2);
		check_token();
		end_test("ctrl_token");

		bp_on = 1'b1;
		for (int p = 0; p < 40; p++)
			send_random_pkt();
		check_token();
		if (!s_ready_low_seen) begin
			$display("s_axis_tready never went low during back-pressure");
			errors++;
		end
		end_test("back_pressure");
		bp_on = 1'b0;

		$display("summary: 5 tests, %0d beats checked, %0d errors", beats_seen, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== verilog/phv_deparser.sv ====
module phv_deparser import rmt_pkg::*; (
	input  logic                  clk,
	input  logic                  aresetn,
	input  pkt_beat_t             pkt_dout,
	input  logic                  pkt_empty,
	output logic                  pkt_rd_en,
	input  phv_t                  phv_dout,
	input  logic                  phv_empty,
	output logic                  phv_rd_en,
	output logic [DATA_WIDTH-1:0] m_axis_tdata,
	output logic                  m_axis_tvalid,
	output logic                  m_axis_tlast,
	input  logic                  m_axis_tready
);

	typedef enum logic {
		ST_HEADER,
		ST_BODY
	} state_t;

	state_t                state_r;
	logic                  in_header;
	logic [DATA_WIDTH-1:0] merged;

	assign in_header = state_r == ST_HEADER;

	// kind nibble kept from the packet, vlan and containers from the phv
	assign merged = {phv_dout.vlan, pkt_dout.data[KIND_LO +: KIND_WIDTH], phv_dout.cont};

	// header beat needs its phv as well
	assign m_axis_tvalid = in_header ? (!pkt_empty && !phv_empty) : !pkt_empty;
	assign m_axis_tdata  = in_header ? merged : pkt_dout.data;
	assign m_axis_tlast  = pkt_dout.last;

	assign pkt_rd_en = m_axis_tvalid && m_axis_tready;
	assign phv_rd_en = pkt_rd_en && pkt_dout.last;  // phv stays at head for the whole packet

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state_r <= ST_HEADER;
		end else if (pkt_rd_en) begin
			state_r <= pkt_dout.last ? ST_HEADER : ST_BODY;
		end
	end

endmodule

// ==== verilog/phv_parser.sv ====
module phv_parser import rmt_pkg::*; (
	input  logic                  clk,
	input  logic                  aresetn,
	input  logic [DATA_WIDTH-1:0] beat_data,
	input  logic                  beat_valid,
	input  logic                  beat_last,
	input  logic                  beat_first,
	output logic                  pkt_wr_en,
	output pkt_beat_t             pkt_din,
	output phv_t                  phv,
	output logic                  phv_valid,
	output logic [CTRL_WIDTH-1:0] ctrl,
	output logic                  ctrl_valid
);

	logic is_ctrl;
	logic hdr_beat;
	action_t act;

	assign is_ctrl  = beat_data[KIND_LO +: KIND_WIDTH] == KIND_CTRL;
	assign hdr_beat = beat_valid && beat_first;

	assign act.op   = beat_data[OP_LO +: OP_WIDTH];
	assign act.csel = beat_data[CSEL_LO +: CSEL_WIDTH];
	assign act.imm  = beat_data[IMM_LO +: CONT_WIDTH];

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			pkt_wr_en  <= 1'b0;
			phv_valid  <= 1'b0;
			ctrl_valid <= 1'b0;
		end else begin
			// the filter only passes the first beat of a control packet
			pkt_wr_en  <= beat_valid && !(beat_first && is_ctrl);
			phv_valid  <= hdr_beat && !is_ctrl;
			ctrl_valid <= hdr_beat && is_ctrl;
		end
	end

	always_ff @(posedge clk) begin
		pkt_din.data <= beat_data;
		pkt_din.last <= beat_last;
		phv.vlan     <= beat_data[VLAN_LO +: VLAN_WIDTH];
		phv.cont     <= beat_data[CONT_LO +: NUM_CONT * CONT_WIDTH];
		// stage, index, then the action entry
		ctrl <= {beat_data[STAGE_LO +: STAGE_WIDTH], beat_data[IDX_LO +: IDX_WIDTH], act};
	end

endmodule

// ==== verilog/pkt_filter.sv ====
module pkt_filter import rmt_pkg::*; (
	input  logic                  clk,
	input  logic                  aresetn,
	input  logic [15:0]           vlan_drop_flags,
	input  logic [DATA_WIDTH-1:0] s_axis_tdata,
	input  logic                  s_axis_tvalid,
	input  logic                  s_axis_tlast,
	output logic                  s_axis_tready,
	input  logic                  pkt_fifo_nearly_full,
	input  logic                  phv_fifo_nearly_full,
	output logic [DATA_WIDTH-1:0] beat_data,
	output logic                  beat_valid,
	output logic                  beat_last,
	output logic                  beat_first,
	output logic [31:0]           ctrl_token
);

	logic first_r;      // next accepted beat opens a packet
	logic body_pass_r;  // body beats of the current packet go on
	logic accept;
	logic drop_now;
	logic ctrl_now;
	logic fwd;

	assign s_axis_tready = !pkt_fifo_nearly_full && !phv_fifo_nearly_full;
	assign accept = s_axis_tvalid && s_axis_tready;

	// only meaningful on a first beat
	assign drop_now = vlan_drop_flags[s_axis_tdata[VLAN_LO +: IDX_WIDTH]];
	assign ctrl_now = s_axis_tdata[KIND_LO +: KIND_WIDTH] == KIND_CTRL;

	assign fwd = accept && (first_r ? !drop_now : body_pass_r);

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			first_r     <= 1'b1;
			body_pass_r <= 1'b0;
			beat_valid  <= 1'b0;
			ctrl_token  <= 32'd0;
		end else begin
			beat_valid <= fwd;
			if (accept) begin
				first_r <= s_axis_tlast;
				// control packets keep only their first beat
				if (first_r)
					body_pass_r <= !drop_now && !ctrl_now;
			end
			if (accept && first_r && ctrl_now && !drop_now)
				ctrl_token <= ctrl_token + 32'd1;  // wraps at 32 bits
		end
	end

	always_ff @(posedge clk) begin
		beat_data  <= s_axis_tdata;
		beat_last  <= s_axis_tlast;
		beat_first <= first_r;
	end

endmodule

// ==== verilog/rmt_top.sv ====
module rmt_top import rmt_pkg::*; (
	input  logic                  clk,
	input  logic                  aresetn,
	input  logic [15:0]           vlan_drop_flags,
	output logic [31:0]           ctrl_token,
	input  logic [DATA_WIDTH-1:0] s_axis_tdata,
	input  logic                  s_axis_tvalid,
	output logic                  s_axis_tready,
	input  logic                  s_axis_tlast,
	output logic [DATA_WIDTH-1:0] m_axis_tdata,
	output logic                  m_axis_tvalid,
	input  logic                  m_axis_tready,
	output logic                  m_axis_tlast
);

	logic [DATA_WIDTH-1:0] beat_data;
	logic                  beat_valid;
	logic                  beat_last;
	logic                  beat_first;

	pkt_beat_t pkt_din;
	pkt_beat_t pkt_dout;
	logic      pkt_wr_en;
	logic      pkt_rd_en;
	logic      pkt_empty;
	logic      pkt_nearly_full;

	phv_t phv_dout;
	logic phv_rd_en;
	logic phv_empty;
	logic phv_nearly_full;

	// index s is the input of stage s, the last phv entry feeds the phv fifo
	phv_t                  stg_phv [NUM_STAGES+1];
	logic [NUM_STAGES:0]   stg_phv_valid;
	logic [CTRL_WIDTH-1:0] stg_ctrl [NUM_STAGES];
	logic [NUM_STAGES-1:0] stg_ctrl_valid;

	pkt_filter filter_i (
		.clk                  (clk),
		.aresetn              (aresetn),
		.vlan_drop_flags      (vlan_drop_flags),
		.s_axis_tdata         (s_axis_tdata),
		.s_axis_tvalid        (s_axis_tvalid),
		.s_axis_tlast         (s_axis_tlast),
		.s_axis_tready        (s_axis_tready),
		.pkt_fifo_nearly_full (pkt_nearly_full),
		.phv_fifo_nearly_full (phv_nearly_full),
		.beat_data            (beat_data),
		.beat_valid           (beat_valid),
		.beat_last            (beat_last),
		.beat_first           (beat_first),
		.ctrl_token           (ctrl_token)
	);

	phv_parser parser_i (
		.clk        (clk),
		.aresetn    (aresetn),
		.beat_data  (beat_data),
		.beat_valid (beat_valid),
		.beat_last  (beat_last),
		.beat_first (beat_first),
		.pkt_wr_en  (pkt_wr_en),
		.pkt_din    (pkt_din),
		.phv        (stg_phv[0]),
		.phv_valid  (stg_phv_valid[0]),
		.ctrl       (stg_ctrl[0]),
		.ctrl_valid (stg_ctrl_valid[0])
	);

	for (genvar s = 0; s < NUM_STAGES; s++) begin : g_stage
		if (s < NUM_STAGES - 1) begin : g_mid
			match_action_stage #(.STAGE_ID(s)) stage_i (
				.clk            (clk),
				.aresetn        (aresetn),
				.phv_in         (stg_phv[s]),
				.phv_valid_in   (stg_phv_valid[s]),
				.ctrl_in        (stg_ctrl[s]),
				.ctrl_valid_in  (stg_ctrl_valid[s]),
				.phv_out        (stg_phv[s+1]),
				.phv_valid_out  (stg_phv_valid[s+1]),
				.ctrl_out       (stg_ctrl[s+1]),
				.ctrl_valid_out (stg_ctrl_valid[s+1])
			);
		end else begin : g_last
			// control words end here
			match_action_stage #(.STAGE_ID(s)) stage_i (
				.clk            (clk),
				.aresetn        (aresetn),
				.phv_in         (stg_phv[s]),
				.phv_valid_in   (stg_phv_valid[s]),
				.ctrl_in        (stg_ctrl[s]),
				.ctrl_valid_in  (stg_ctrl_valid[s]),
				.phv_out        (stg_phv[s+1]),
				.phv_valid_out  (stg_phv_valid[s+1]),
				.ctrl_out       (),
				.ctrl_valid_out ()
			);
		end
	end

	sync_fifo #(.payload_t(pkt_beat_t), .DEPTH(PKT_FIFO_DEPTH)) pkt_fifo_i (
		.clk         (clk),
		.aresetn     (aresetn),
		.wr_en       (pkt_wr_en),
		.din         (pkt_din),
		.rd_en       (pkt_rd_en),
		.dout        (pkt_dout),
		.empty       (pkt_empty),
		.nearly_full (pkt_nearly_full)
	);

	sync_fifo #(.payload_t(phv_t), .DEPTH(PHV_FIFO_DEPTH)) phv_fifo_i (
		.clk         (clk),
		.aresetn     (aresetn),
		.wr_en       (stg_phv_valid[NUM_STAGES]),
		.din         (stg_phv[NUM_STAGES]),
		.rd_en       (phv_rd_en),
		.dout        (phv_dout),
		.empty       (phv_empty),
		.nearly_full (phv_nearly_full)
	);

	phv_deparser deparser_i (
		.clk           (clk),
		.aresetn       (aresetn),
		.pkt_dout      (pkt_dout),
		.pkt_empty     (pkt_empty),
		.pkt_rd_en     (pkt_rd_en),
		.phv_dout      (phv_dout),
		.phv_empty     (phv_empty),
		.phv_rd_en     (phv_rd_en),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tready (m_axis_tready)
	);

endmodule

// ==== verilog/sync_fifo.sv ====
module sync_fifo import rmt_pkg::*; #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 8
) (
	input  logic     clk,
	input  logic     aresetn,
	input  logic     wr_en,
	input  payload_t din,
	input  logic     rd_en,
	output payload_t dout,
	output logic     empty,
	output logic     nearly_full
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	assign do_wr       = wr_en && (count != CNT_W'(DEPTH));  // never overwrite
	assign do_rd       = rd_en && !empty;
	assign empty       = count == '0;
	assign nearly_full = count >= CNT_W'(DEPTH - FIFO_SLACK);
	assign dout        = mem[rd_ptr];  // fall-through head

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

endmodule
